//--- hw/niuAlu.sv
`timescale 1ns/1ps

module niuAlu (
    input  logic          clk,
    input  niuPkg::ctrl_t ctrl,
    input  niuPkg::word_t bus,
    output niuPkg::word_t aluOut
);

    niuPkg::word_t                      opA;
    niuPkg::word_t                      opB;
    logic [$clog2(niuPkg::wordW)-1:0]   shamt;

    assign shamt = opB[$clog2(niuPkg::wordW)-1:0];   // Low bits of B only

    always_ff @(posedge clk) begin
        if (ctrl.ldA) begin
            opA <= bus;
        end
        if (ctrl.ldB) begin
            opB <= bus;
        end
    end

    // Result registered every cycle; the FSM reads it one cycle later
    always_ff @(posedge clk) begin
        case (ctrl.aluFunc)
            niuPkg::aluSub: aluOut <= opA - opB;
            niuPkg::aluAdd: aluOut <= opA + opB;
            niuPkg::aluNot: aluOut <= ~opA;
            niuPkg::aluAnd: aluOut <= opA & opB;
            niuPkg::aluOr:  aluOut <= opA | opB;
            niuPkg::aluXor: aluOut <= opA ^ opB;
            niuPkg::aluSul: aluOut <= opA << shamt;
            niuPkg::aluSur: aluOut <= opA >> shamt;
            niuPkg::aluSsr: aluOut <= $signed(opA) >>> shamt;
            // Unsigned compares
            niuPkg::aluEq:  aluOut <= niuPkg::word_t'(opA == opB);
            niuPkg::aluNeq: aluOut <= niuPkg::word_t'(opA != opB);
            niuPkg::aluLt:  aluOut <= niuPkg::word_t'(opA < opB);
            niuPkg::aluLeq: aluOut <= niuPkg::word_t'(opA <= opB);
            default:        aluOut <= '0;
        endcase
    end

endmodule

//--- hw/niuControl.sv
`timescale 1ns/1ps

module niuControl (
    input  logic                 clk,
    input  logic                 reset,
    input  niuPkg::instrFields_t fields,
    input  logic                 branchTaken,
    output niuPkg::ctrl_t        ctrl,
    output logic                 halted
);

    niuPkg::state_e   state;
    niuPkg::state_e   nextState;
    niuPkg::aluFunc_e brFunc;
    logic             isRegOp;
    logic             op2Legal;

    assign isRegOp = (fields.op1 == niuPkg::opAlu);
    assign halted = (state == niuPkg::stHalt);

    // Kept register-register functions
    always_comb begin
        case (fields.op2)
            niuPkg::aluSub, niuPkg::aluAdd, niuPkg::aluNot, niuPkg::aluAnd,
            niuPkg::aluOr, niuPkg::aluXor, niuPkg::aluSul, niuPkg::aluSur,
            niuPkg::aluSsr, niuPkg::aluEq, niuPkg::aluNeq, niuPkg::aluLt,
            niuPkg::aluLeq: op2Legal = 1'b1;
            default:        op2Legal = 1'b0;
        endcase
    end

    always_comb begin
        case (fields.op1)
            niuPkg::opBne: brFunc = niuPkg::aluNeq;
            niuPkg::opBlt: brFunc = niuPkg::aluLt;
            niuPkg::opBle: brFunc = niuPkg::aluLeq;
            default:       brFunc = niuPkg::aluEq;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= niuPkg::stFetch;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        ctrl = '0;
        nextState = state;
        case (state)
            niuPkg::stFetch: begin
                ctrl.ldIr = 1'b1;
                ctrl.incPc = 1'b1;
                nextState = niuPkg::stDecode;
            end
            niuPkg::stDecode: begin
                case (fields.op1)
                    niuPkg::opAlu:
                        nextState = op2Legal ? niuPkg::stAluB : niuPkg::stHalt;
                    niuPkg::opAddi, niuPkg::opAndi, niuPkg::opOri, niuPkg::opXori,
                    niuPkg::opSuli, niuPkg::opSuri, niuPkg::opSsri:
                        nextState = niuPkg::stAluB;
                    niuPkg::opLw, niuPkg::opSw:
                        nextState = niuPkg::stMemA;
                    niuPkg::opBeq, niuPkg::opBne, niuPkg::opBlt, niuPkg::opBle:
                        nextState = niuPkg::stBrA;
                    niuPkg::opJal:
                        nextState = niuPkg::stJalLink;
                    default:
                        nextState = niuPkg::stHalt;   // Unknown opcode
                endcase
            end

            // ALU ops, B first so A can come from rx either way
            niuPkg::stAluB: begin
                ctrl.ldB = 1'b1;
                if (isRegOp) begin
                    ctrl.busSrc = niuPkg::busReg;
                    ctrl.regSel = fields.ry;
                end else begin
                    ctrl.busSrc = niuPkg::busImm;
                end
                nextState = niuPkg::stAluA;
            end
            niuPkg::stAluA: begin
                ctrl.ldA = 1'b1;
                ctrl.busSrc = niuPkg::busReg;
                ctrl.regSel = fields.rx;
                nextState = niuPkg::stAluExec;
            end
            niuPkg::stAluExec: begin
                ctrl.aluFunc = isRegOp ? niuPkg::aluFunc_e'(fields.op2)
                                       : niuPkg::aluFunc_e'(fields.op1);
                nextState = niuPkg::stAluWb;
            end
            niuPkg::stAluWb: begin
                ctrl.busSrc = niuPkg::busAlu;
                ctrl.wrReg = 1'b1;
                ctrl.regSel = isRegOp ? fields.rz : fields.ry;   // rz overlaps imm
                nextState = niuPkg::stFetch;
            end

            // LW and SW share the address computation
            niuPkg::stMemA: begin
                ctrl.ldA = 1'b1;
                ctrl.busSrc = niuPkg::busReg;
                ctrl.regSel = fields.rx;
                nextState = niuPkg::stMemB;
            end
            niuPkg::stMemB: begin
                ctrl.ldB = 1'b1;
                ctrl.busSrc = niuPkg::busImm;
                nextState = niuPkg::stMemExec;
            end
            niuPkg::stMemExec: begin
                ctrl.aluFunc = niuPkg::aluAdd;
                nextState = niuPkg::stMemMar;
            end
            niuPkg::stMemMar: begin
                ctrl.ldMar = 1'b1;
                ctrl.busSrc = niuPkg::busAlu;
                nextState = (fields.op1 == niuPkg::opLw) ? niuPkg::stLwMdr
                                                         : niuPkg::stSwWrite;
            end
            niuPkg::stLwMdr: nextState = niuPkg::stLwWb;   // MDR loads from MAR
            niuPkg::stLwWb: begin
                ctrl.busSrc = niuPkg::busMem;
                ctrl.wrReg = 1'b1;
                ctrl.regSel = fields.ry;
                nextState = niuPkg::stFetch;
            end
            niuPkg::stSwWrite: begin
                ctrl.busSrc = niuPkg::busReg;
                ctrl.regSel = fields.ry;
                ctrl.wrMem = 1'b1;
                nextState = niuPkg::stFetch;
            end

            niuPkg::stBrA: begin
                ctrl.ldA = 1'b1;
                ctrl.busSrc = niuPkg::busReg;
                ctrl.regSel = fields.rx;
                nextState = niuPkg::stBrB;
            end
            niuPkg::stBrB: begin
                ctrl.ldB = 1'b1;
                ctrl.busSrc = niuPkg::busReg;
                ctrl.regSel = fields.ry;
                nextState = niuPkg::stBrCmp;
            end
            niuPkg::stBrCmp: begin
                ctrl.aluFunc = brFunc;
                nextState = niuPkg::stBrTest;
            end
            // Compare result visible now; A takes the PC in case the branch is taken
            niuPkg::stBrTest: begin
                ctrl.ldA = 1'b1;
                ctrl.busSrc = niuPkg::busPc;
                nextState = branchTaken ? niuPkg::stBrOff : niuPkg::stFetch;
            end
            niuPkg::stBrOff: begin
                ctrl.ldB = 1'b1;
                ctrl.busSrc = niuPkg::busImmShift;
                nextState = niuPkg::stBrExec;
            end
            niuPkg::stBrExec: begin
                ctrl.aluFunc = niuPkg::aluAdd;
                nextState = niuPkg::stBrJump;
            end
            niuPkg::stBrJump: begin
                ctrl.ldPc = 1'b1;
                ctrl.busSrc = niuPkg::busAlu;
                nextState = niuPkg::stFetch;
            end

            niuPkg::stJalLink: begin
                ctrl.wrReg = 1'b1;
                ctrl.busSrc = niuPkg::busPc;   // Already incremented
                ctrl.regSel = fields.ry;
                nextState = niuPkg::stJalJump;
            end
            niuPkg::stJalJump: begin
                ctrl.ldPc = 1'b1;
                ctrl.busSrc = niuPkg::busReg;
                ctrl.regSel = fields.rx;
                nextState = niuPkg::stFetch;
            end

            niuPkg::stHalt: nextState = niuPkg::stHalt;   // Only reset leaves
            default:        nextState = niuPkg::stHalt;
        endcase
    end

endmodule

//--- hw/niuCore.sv
`timescale 1ns/1ps

module niuCore (
    input  logic                clk,
    input  logic                reset,
    input  niuPkg::progLoad_t   progLoad,
    output niuPkg::storeEvent_t store,
    output logic                halted
);

    niuPkg::ctrl_t        ctrl;
    niuPkg::instrFields_t fields;
    niuPkg::word_t        bus;
    niuPkg::word_t        regData;
    niuPkg::word_t        memData;
    niuPkg::word_t        aluOut;
    niuPkg::word_t        instr;
    niuPkg::word_t        pc;
    niuPkg::word_t        mar;

    niuControl control (
        .clk,
        .reset,
        .fields,
        .branchTaken(aluOut[0]),   // Compare results are 0 or 1
        .ctrl,
        .halted
    );

    niuDatapath datapath (
        .clk, .reset, .ctrl, .instr, .regData, .memData, .aluOut,
        .bus, .pc, .mar, .fields
    );

    niuRegFile regFile (.clk, .reset, .ctrl, .bus, .regData);

    niuAlu alu (.clk, .ctrl, .bus, .aluOut);

    niuMemory memory (
        .clk, .reset, .ctrl, .bus, .pc, .mar, .progLoad,
        .instr, .memData, .store
    );

endmodule

//--- hw/niuDatapath.sv
`timescale 1ns/1ps

module niuDatapath (
    input  logic                 clk,
    input  logic                 reset,
    input  niuPkg::ctrl_t        ctrl,
    input  niuPkg::word_t        instr,
    input  niuPkg::word_t        regData,
    input  niuPkg::word_t        memData,
    input  niuPkg::word_t        aluOut,
    output niuPkg::word_t        bus,
    output niuPkg::word_t        pc,
    output niuPkg::word_t        mar,
    output niuPkg::instrFields_t fields
);

    niuPkg::word_t ir;
    niuPkg::word_t immExt;
    niuPkg::word_t immShift;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= niuPkg::pcStart;
            ir <= '0;
        end else begin
            if (ctrl.ldPc) begin
                pc <= bus;
            end else if (ctrl.incPc) begin
                pc <= pc + niuPkg::instrBytes;
            end
            if (ctrl.ldIr) begin
                ir <= instr;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.ldMar) begin
            mar <= bus;
        end
    end

    // Instruction layout; rz, op2 and imm overlap
    assign fields = '{
        op1: ir[31:27],
        rx:  ir[26:22],
        ry:  ir[21:17],
        rz:  ir[16:12],
        op2: ir[4:0],
        imm: ir[16:0]
    };

    assign immExt = {{(niuPkg::wordW - niuPkg::immW){fields.imm[niuPkg::immW-1]}},
                     fields.imm};
    assign immShift = immExt * niuPkg::instrBytes;   // Branch offset in words

    // Bus source select
    always_comb begin
        case (ctrl.busSrc)
            niuPkg::busPc:       bus = pc;
            niuPkg::busReg:      bus = regData;
            niuPkg::busMem:      bus = memData;
            niuPkg::busAlu:      bus = aluOut;
            niuPkg::busImm:      bus = immExt;
            niuPkg::busImmShift: bus = immShift;
            default:             bus = '0;   // Idle bus
        endcase
    end

endmodule

//--- hw/niuMemory.sv
`timescale 1ns/1ps

module niuMemory (
    input  logic                clk,
    input  logic                reset,
    input  niuPkg::ctrl_t       ctrl,
    input  niuPkg::word_t       bus,
    input  niuPkg::word_t       pc,
    input  niuPkg::word_t       mar,
    input  niuPkg::progLoad_t   progLoad,
    output niuPkg::word_t       instr,
    output niuPkg::word_t       memData,
    output niuPkg::storeEvent_t store
);

    niuPkg::word_t               instrMem [niuPkg::memWords];
    niuPkg::word_t               dataMem [niuPkg::memWords];
    logic [niuPkg::memIndexW-1:0] pcIndex;
    logic [niuPkg::memIndexW-1:0] marIndex;

    // Byte addresses to word index
    assign pcIndex = pc[niuPkg::memIndexW+1:2];
    assign marIndex = mar[niuPkg::memIndexW+1:2];

    // Program loads are taken only while the core is held in reset
    always_ff @(posedge clk) begin
        if (reset && progLoad.valid) begin
            instrMem[progLoad.index] <= progLoad.data;
        end
    end

    assign instr = instrMem[pcIndex];

    always_ff @(posedge clk) begin
        if (ctrl.wrMem) begin
            dataMem[marIndex] <= bus;
        end
        memData <= dataMem[marIndex];   // MDR follows MAR
    end

    // Report each SW as it writes
    assign store = '{valid: ctrl.wrMem, addr: mar, data: bus};

endmodule

//--- hw/niuPkg.sv
package niuPkg;

    localparam int wordW = 32;
    localparam int regW = 5;
    localparam int opW = 5;
    localparam int immW = 17;
    localparam int memWords = 2048;
    localparam int memIndexW = 11;   // log2 of memWords

    typedef logic [wordW-1:0] word_t;
    typedef logic [regW-1:0] regSel_t;

    localparam word_t instrBytes = 32'd4;   // PC step per instruction
    localparam word_t pcStart = 32'h0;

    // Primary opcodes, instruction bits 31:27
    typedef enum logic [opW-1:0] {
        opAlu  = 5'b00000,   // Register-register, function in op2
        opAddi = 5'b00001,
        opAndi = 5'b00101,
        opOri  = 5'b00110,
        opXori = 5'b00111,
        opSuli = 5'b01000,
        opSuri = 5'b01010,
        opSsri = 5'b01011,
        opLw   = 5'b10000,
        opSw   = 5'b10011,
        opBeq  = 5'b11000,
        opBne  = 5'b11001,
        opBlt  = 5'b11010,
        opBle  = 5'b11011,
        opJal  = 5'b11111
    } op1_e;

    // Immediate opcodes share these codes
    typedef enum logic [opW-1:0] {
        aluSub = 5'b00000,
        aluAdd = 5'b00001,
        aluNot = 5'b00100,
        aluAnd = 5'b00101,
        aluOr  = 5'b00110,
        aluXor = 5'b00111,
        aluSul = 5'b01000,
        aluSur = 5'b01010,
        aluSsr = 5'b01011,
        aluEq  = 5'b10000,
        aluNeq = 5'b10001,
        aluLt  = 5'b10010,
        aluLeq = 5'b10011
    } aluFunc_e;

    typedef enum logic [4:0] {
        stFetch, stDecode,
        stAluB, stAluA, stAluExec, stAluWb,
        stMemA, stMemB, stMemExec, stMemMar, stLwMdr, stLwWb, stSwWrite,
        stBrA, stBrB, stBrCmp, stBrTest, stBrOff, stBrExec, stBrJump,
        stJalLink, stJalJump,
        stHalt
    } state_e;

    typedef enum logic [2:0] {
        busNone, busPc, busReg, busMem, busAlu, busImm, busImmShift
    } busSrc_e;

    typedef struct packed {
        logic     ldPc;
        logic     incPc;
        logic     ldIr;
        logic     ldMar;
        logic     wrMem;
        logic     wrReg;
        logic     ldA;
        logic     ldB;
        regSel_t  regSel;
        aluFunc_e aluFunc;
        busSrc_e  busSrc;
    } ctrl_t;

    typedef struct packed {
        logic [opW-1:0]  op1;
        regSel_t         rx;
        regSel_t         ry;
        regSel_t         rz;
        logic [opW-1:0]  op2;
        logic [immW-1:0] imm;
    } instrFields_t;

    typedef struct packed {
        logic                 valid;
        logic [memIndexW-1:0] index;   // Word index, not byte address
        word_t                data;
    } progLoad_t;

    typedef struct packed {
        logic  valid;
        word_t addr;   // Byte address
        word_t data;
    } storeEvent_t;

endpackage

//--- hw/niuRegFile.sv
`timescale 1ns/1ps

module niuRegFile (
    input  logic          clk,
    input  logic          reset,
    input  niuPkg::ctrl_t ctrl,
    input  niuPkg::word_t bus,
    output niuPkg::word_t regData
);

    niuPkg::word_t regs [2**niuPkg::regW];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            regs <= '{default: '0};
        end else if (ctrl.wrReg) begin
            regs[ctrl.regSel] <= bus;
        end
    end

    // Same selector for read and write
    assign regData = regs[ctrl.regSel];

endmodule

//--- niuCore.f
hw/niuPkg.sv
hw/niuAlu.sv
hw/niuRegFile.sv
hw/niuMemory.sv
hw/niuDatapath.sv
hw/niuControl.sv
hw/niuCore.sv
sim/niuCore_assert.sv
sim/niuChecker.sv
sim/niuCoreTb.sv

//--- sim/niuChecker.sv
`timescale 1ns/1ps

module niuChecker #(
    parameter int stepLimit = 10000
) (
    input  logic                clk,
    input  logic                reset,
    input  niuPkg::progLoad_t   progLoad,
    input  niuPkg::storeEvent_t store,
    input  logic                halted,
    input  logic                runDone,
    output int                  mismatchCount,
    output int                  otherCount
);

    typedef logic [63:0] storePair_t;   // {addr, data}
    typedef storePair_t storeList_t [$];

    niuPkg::word_t progMem [int];   // Copy of the loaded program
    storeList_t    expected;
    int            storeIdx;
    logic          modelReady;
    logic          modelHalts;
    logic          haltSeen;
    logic          finalDone;

    // Returns 0 for a function code the ISA does not define
    function automatic logic evalAlu(input logic [4:0] func, input niuPkg::word_t a,
                                     input niuPkg::word_t b, output niuPkg::word_t res);
        logic legal;
        legal = 1'b1;
        res = '0;
        case (func)
            niuPkg::aluSub: res = a - b;
            niuPkg::aluAdd: res = a + b;
            niuPkg::aluNot: res = ~a;
            niuPkg::aluAnd: res = a & b;
            niuPkg::aluOr:  res = a | b;
            niuPkg::aluXor: res = a ^ b;
            niuPkg::aluSul: res = a << b[4:0];
            niuPkg::aluSur: res = a >> b[4:0];
            niuPkg::aluSsr: res = (a >> b[4:0]) | (a[31] ? ~(32'hFFFF_FFFF >> b[4:0]) : 32'h0);
            niuPkg::aluEq:  res = {31'b0, a == b};
            niuPkg::aluNeq: res = {31'b0, a != b};
            niuPkg::aluLt:  res = {31'b0, a < b};   // Unsigned compares
            niuPkg::aluLeq: res = {31'b0, a <= b};
            default:        legal = 1'b0;
        endcase
        return legal;
    endfunction

    // ISA model of the whole program, returns the stores in order
    function automatic storeList_t runModel(output logic halts);
        storeList_t    stores;
        niuPkg::word_t regs [32];
        niuPkg::word_t dataMem [int];
        niuPkg::word_t pc;
        niuPkg::word_t ins;
        niuPkg::word_t immExt;
        niuPkg::word_t addr;
        niuPkg::word_t res;
        logic [4:0]    op1;
        logic [4:0]    rx;
        logic [4:0]    ry;
        logic          taken;
        int            idx;
        int            steps;

        foreach (regs[i]) begin
            regs[i] = '0;
        end
        pc = niuPkg::pcStart;
        halts = 1'b0;
        steps = 0;
        while (!halts && steps < stepLimit) begin
            idx = int'(pc[12:2]);
            if (!progMem.exists(idx)) begin
                break;   // Ran off the loaded program
            end
            ins = progMem[idx];
            pc = pc + 32'd4;
            steps++;
            op1 = ins[31:27];
            rx = ins[26:22];
            ry = ins[21:17];
            immExt = {{15{ins[16]}}, ins[16:0]};
            addr = regs[rx] + immExt;
            case (op1)
                niuPkg::opAlu: begin
                    if (evalAlu(ins[4:0], regs[rx], regs[ry], res)) begin
                        regs[ins[16:12]] = res;
                    end else begin
                        halts = 1'b1;
                    end
                end
                niuPkg::opAddi, niuPkg::opAndi, niuPkg::opOri, niuPkg::opXori,
                niuPkg::opSuli, niuPkg::opSuri, niuPkg::opSsri: begin
                    void'(evalAlu(op1, regs[rx], immExt, res));
                    regs[ry] = res;
                end
                niuPkg::opLw: begin
                    regs[ry] = dataMem.exists(int'(addr[12:2])) ? dataMem[int'(addr[12:2])] : 'x;
                end
                niuPkg::opSw: begin
                    dataMem[int'(addr[12:2])] = regs[ry];
                    stores.push_back({addr, regs[ry]});
                end
                niuPkg::opBeq, niuPkg::opBne, niuPkg::opBlt, niuPkg::opBle: begin
                    case (op1)
                        niuPkg::opBeq: taken = (regs[rx] == regs[ry]);
                        niuPkg::opBne: taken = (regs[rx] != regs[ry]);
                        niuPkg::opBlt: taken = (regs[rx] < regs[ry]);
                        default:       taken = (regs[rx] <= regs[ry]);
                    endcase
                    if (taken) begin
                        pc = pc + (immExt << 2);
                    end
                end
                niuPkg::opJal: begin
                    regs[ry] = pc;   // Link first, then jump
                    pc = regs[rx];
                end
                default: halts = 1'b1;
            endcase
        end
        return stores;
    endfunction

    task automatic compareStore();
        niuPkg::word_t expAddr;
        niuPkg::word_t expData;
        {expAddr, expData} = expected[storeIdx];
        if (store.addr !== expAddr) begin
            mismatchCount++;
            $display("Mismatch store.addr: got %08h, expected %08h (store %0d)",
                     store.addr, expAddr, storeIdx);
        end
        if (store.data !== expData) begin
            mismatchCount++;
            $display("Mismatch store.data: got %08h, expected %08h (store %0d)",
                     store.data, expData, storeIdx);
        end
        storeIdx++;
    endtask

    always @(posedge clk) begin
        if (reset) begin
            if (progLoad.valid) begin
                progMem[int'(progLoad.index)] = progLoad.data;
            end
            modelReady = 1'b0;
            haltSeen = 1'b0;
            finalDone = 1'b0;
            storeIdx = 0;
            mismatchCount = 0;
            otherCount = 0;
        end else begin
            if (!modelReady) begin
                expected = runModel(modelHalts);
                modelReady = 1'b1;
                if (!modelHalts) begin
                    otherCount++;
                    $display("Reference model did not reach a halt within %0d instructions",
                             stepLimit);
                end
            end
            if (store.valid) begin
                if (haltSeen) begin
                    otherCount++;
                    $display("A store happened after the core halted");
                end else if (storeIdx >= expected.size()) begin
                    otherCount++;
                    $display("Extra store beyond the %0d expected ones", expected.size());
                end else begin
                    compareStore();
                end
            end
            if (halted) begin
                haltSeen = 1'b1;
            end
            if (runDone && !finalDone) begin
                finalDone = 1'b1;
                if (storeIdx < expected.size()) begin
                    otherCount++;
                    $display("Missing stores: saw %0d of %0d", storeIdx, expected.size());
                end
                if (!haltSeen) begin
                    otherCount++;
                    $display("The core never raised halted");
                end
            end
        end
    end

endmodule

//--- sim/niuCoreTb.sv
`timescale 1ns/1ps

module niuCoreTb;

    localparam int period = 40;
    localparam int seed = 52387;
    localparam int resetCycles = 3;
    localparam int stepBudget = 20000;   // Model instruction limit
    localparam logic [4:0] baseReg = 5'd10;   // Store slot base
    localparam logic [4:0] memReg = 5'd11;   // Load/store test base

    localparam niuPkg::aluFunc_e regOps [13] = '{
        niuPkg::aluSub, niuPkg::aluAdd, niuPkg::aluNot, niuPkg::aluAnd, niuPkg::aluOr,
        niuPkg::aluXor, niuPkg::aluSul, niuPkg::aluSur, niuPkg::aluSsr, niuPkg::aluEq,
        niuPkg::aluNeq, niuPkg::aluLt, niuPkg::aluLeq
    };
    localparam niuPkg::op1_e immOps [7] = '{
        niuPkg::opAddi, niuPkg::opAndi, niuPkg::opOri, niuPkg::opXori,
        niuPkg::opSuli, niuPkg::opSuri, niuPkg::opSsri
    };
    localparam niuPkg::op1_e brOps [4] = '{
        niuPkg::opBeq, niuPkg::opBne, niuPkg::opBlt, niuPkg::opBle
    };
    // Loop operands per branch that keep it taken while r6 is not zero
    localparam logic [4:0] loopRx [4] = '{5'd15, 5'd6, 5'd0, 5'd12};
    localparam logic [4:0] loopRy [4] = '{5'd0, 5'd0, 5'd6, 5'd6};
    localparam logic [16:0] memOffsets [2] = '{17'h1FFF4, 17'h00014};

    logic                clk = 1'b0;
    logic                reset;
    logic                runDone;
    logic                timedOut;
    niuPkg::progLoad_t   progLoad;
    niuPkg::storeEvent_t store;
    logic                halted;
    int                  mismatchCount;
    int                  otherCount;
    int                  assertFails;
    int                  slotNext;
    int                  cycles;
    int                  cycleLimit;
    niuPkg::word_t       prog [$];

    always #(period / 2) clk = ~clk;

    niuCore dut (.clk, .reset, .progLoad, .store, .halted);

    niuChecker #(.stepLimit(stepBudget)) storeCheck (
        .clk, .reset, .progLoad, .store, .halted, .runDone, .mismatchCount, .otherCount
    );

    bind niuControl niuControlAssert controlChecks (
        .clk(clk), .reset(reset), .ctrl(ctrl), .state(state), .halted(halted)
    );

    function automatic niuPkg::word_t encodeReg(input logic [4:0] func, input logic [4:0] rx,
                                                input logic [4:0] ry, input logic [4:0] rz);
        return {niuPkg::opAlu, rx, ry, rz, 7'd0, func};
    endfunction

    function automatic niuPkg::word_t encodeImm(input logic [4:0] op, input logic [4:0] rx,
                                                input logic [4:0] ry, input logic [16:0] imm);
        return {op, rx, ry, imm};
    endfunction

    task automatic loadConst(input logic [4:0] r, input niuPkg::word_t value);
        prog.push_back(encodeImm(niuPkg::opAddi, 5'd0, r, {1'b0, value[31:16]}));
        prog.push_back(encodeImm(niuPkg::opSuli, r, r, 17'd16));
        prog.push_back(encodeImm(niuPkg::opOri, r, r, {1'b0, value[15:0]}));
    endtask

    // Each call gets its own address off the base register
    task automatic storeSlot(input logic [4:0] r);
        prog.push_back(encodeImm(niuPkg::opSw, baseReg, r, 17'(slotNext * 4)));
        slotNext++;
    endtask

    task automatic buildProgram();
        niuPkg::word_t valA;
        niuPkg::word_t valB;
        int            k;
        prog.push_back(encodeImm(niuPkg::opAddi, 5'd0, baseReg, 17'h100));
        prog.push_back(encodeImm(niuPkg::opAddi, 5'd0, memReg, 17'h800));
        prog.push_back(encodeImm(niuPkg::opAddi, 5'd0, 5'd12, 17'd1));
        foreach (regOps[i]) begin
            loadConst(5'd1, $urandom);
            loadConst(5'd2, $urandom);
            prog.push_back(encodeReg(regOps[i], 5'd1, 5'd2, 5'd3));
            storeSlot(5'd3);
        end
        foreach (immOps[i]) begin
            loadConst(5'd1, $urandom);
            prog.push_back(encodeImm(immOps[i], 5'd1, 5'd3, 17'($urandom)));
            storeSlot(5'd3);
        end
        foreach (memOffsets[i]) begin   // SW then LW at the same address
            loadConst(5'd4, $urandom);
            prog.push_back(encodeImm(niuPkg::opSw, memReg, 5'd4, memOffsets[i]));
            prog.push_back(encodeImm(niuPkg::opLw, memReg, 5'd5, memOffsets[i]));
            storeSlot(5'd5);
        end
        // Forward branches over one store; equal, less and greater operands
        foreach (brOps[i]) begin
            for (int c = 0; c < 3; c++) begin
                valA = ($urandom >> 1) | 32'h100;
                k = $urandom_range(255, 1);
                valB = (c == 0) ? valA : (c == 1) ? valA + k : valA - k;
                loadConst(5'd1, valA);
                loadConst(5'd2, valB);
                prog.push_back(encodeImm(brOps[i], 5'd1, 5'd2, 17'd1));
                storeSlot(5'd1);   // Skipped when taken
                storeSlot(5'd2);
            end
        end
        // Backward branches through a countdown loop of three passes
        foreach (brOps[i]) begin
            prog.push_back(encodeImm(niuPkg::opAddi, 5'd0, 5'd6, 17'd3));
            storeSlot(5'd6);
            prog.push_back(encodeImm(niuPkg::opAddi, 5'd6, 5'd6, 17'h1FFFF));
            prog.push_back(encodeReg(niuPkg::aluEq, 5'd6, 5'd0, 5'd15));
            prog.push_back(encodeImm(brOps[i], loopRx[i], loopRy[i], 17'h1FFFC));
            storeSlot(5'd6);
        end
        prog.push_back(encodeImm(niuPkg::opAddi, 5'd0, 5'd8, 17'((prog.size() + 3) * 4)));
        prog.push_back(encodeImm(niuPkg::opJal, 5'd8, 5'd9, 17'd0));
        storeSlot(5'd1);   // Jumped over
        storeSlot(5'd9);   // Return address
        prog.push_back({5'b00010, 27'd0});   // Opcode not in the ISA
        storeSlot(5'd1);
    endtask

    initial begin
        reset = 1'b1;
        progLoad = '0;
        runDone = 1'b0;
        timedOut = 1'b0;
        slotNext = 0;
        void'($urandom(seed));
        buildProgram();
        cycleLimit = prog.size() * 10 * 2 + 100;
        foreach (prog[i]) begin
            @(negedge clk);
            progLoad = '{valid: 1'b1, index: i[niuPkg::memIndexW-1:0], data: prog[i]};
        end
        @(negedge clk);
        progLoad = '0;
        repeat (resetCycles) @(negedge clk);
        reset = 1'b0;

        cycles = 0;
        while (!halted && cycles < cycleLimit) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted) begin
            timedOut = 1'b1;
            $display("Timeout: halted did not rise within %0d cycles", cycleLimit);
        end
        repeat (4) @(negedge clk);   // Room for a stray store after halt
        runDone = 1'b1;
        repeat (2) @(negedge clk);
        assertFails = dut.control.controlChecks.failCount;
        $display("Error counts: %0d mismatch, %0d other, %0d assertion",
                 mismatchCount, otherCount + int'(timedOut), assertFails);
        if (mismatchCount == 0 && otherCount == 0 && assertFails == 0 && !timedOut) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- sim/niuCore_assert.sv
`timescale 1ns/1ps

module niuControlAssert (
    input logic           clk,
    input logic           reset,
    input niuPkg::ctrl_t  ctrl,
    input niuPkg::state_e state,
    input logic           halted
);

    int failCount = 0;   // Read by the testbench at the end of the run

    haltLowAfterReset: assert property (@(posedge clk) reset |=> !halted)
        else begin
            failCount++;
            $error("halted is high in the cycle after reset");
        end

    // Only reset leaves the halt state
    haltSticky: assert property (@(posedge clk) disable iff (reset) halted |=> halted)
        else begin
            failCount++;
            $error("halted fell without a reset");
        end

    // The SW write needs MAR loaded in the cycle before
    wrMemOnlyInSw: assert property (@(posedge clk) disable iff (reset)
        ctrl.wrMem |-> state == niuPkg::stSwWrite && $past(ctrl.ldMar))
        else begin
            failCount++;
            $error("wrMem set outside the SW write state or without MAR loaded before");
        end

    // A PC load never overlaps the increment and leads straight into a fetch
    pcLoadExclusive: assert property (@(posedge clk) disable iff (reset)
        ctrl.ldPc |-> !ctrl.incPc ##1 (ctrl.ldIr && ctrl.incPc))
        else begin
            failCount++;
            $error("ldPc overlapped incPc or was not followed by a fetch");
        end

endmodule
